// ==== rv_decode_pkg.sv ====
/* RV32IM decode types and encodings. F, W-forms and custom GPU opcodes are not decoded.
   The instruction word is a packed union viewed in the six base formats. */
`default_nettype none

package rv_decode_pkg;

    localparam int XLEN        = 32;
    localparam int NUM_WARPS   = 4;
    localparam int WID_W       = $clog2(NUM_WARPS);
    localparam int NUM_THREADS = 4;
    localparam int NR_W        = 5;
    localparam int OP_W        = 4;
    localparam int MOD_W       = 2;
    localparam int CSR_ADDR_W  = 12;

    // Major opcodes, instr[6:0]
    localparam logic [6:0] OPC_I     = 7'b0010011;
    localparam logic [6:0] OPC_R     = 7'b0110011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;
    localparam logic [6:0] OPC_B     = 7'b1100011;
    localparam logic [6:0] OPC_L     = 7'b0000011;
    localparam logic [6:0] OPC_S     = 7'b0100011;
    localparam logic [6:0] OPC_FENCE = 7'b0001111;
    localparam logic [6:0] OPC_SYS   = 7'b1110011;

    // SFU ops track funct3[1:0]
    localparam logic [OP_W-1:0] SFU_CSRRW = 4'd1;
    localparam logic [OP_W-1:0] SFU_CSRRS = 4'd2;
    localparam logic [OP_W-1:0] SFU_CSRRC = 4'd3;
    localparam logic [OP_W-1:0] LSU_FENCE = 4'd15; // loads/stores use {is_store, funct3}

    typedef enum logic [1:0] {
        EX_ALU = 2'd0,
        EX_LSU = 2'd1,
        EX_SFU = 2'd2
    } ex_type_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR,
        BR_ECALL, BR_EBREAK, BR_URET, BR_SRET, BR_MRET
    } br_op_e;

    typedef enum logic [3:0] {
        MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU,
        MUL_DIV, MUL_DIVU, MUL_REM, MUL_REMU
    } mul_op_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_I_SH, IMM_S, IMM_B, IMM_U, IMM_J, IMM_CSR
    } imm_fmt_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        logic [WID_W-1:0]       wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [XLEN-1:0]        pc;
        instr_u                 instr;
    } fetch_t;

    typedef struct packed {
        logic [WID_W-1:0]       wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [XLEN-1:0]        pc;
        ex_type_e               ex_type;
        logic [OP_W-1:0]        op_type;
        logic [MOD_W-1:0]       op_mod;  // [0] branch/jump, [1] M-extension
        logic                   use_pc;
        logic                   use_imm;
        logic [XLEN-1:0]        imm;
        logic                   wb;
        logic [NR_W-1:0]        rd;
        logic [NR_W-1:0]        rs1;
        logic [NR_W-1:0]        rs2;
    } decoded_t;

    typedef struct packed {
        logic [WID_W-1:0] wid;
        logic             is_wstall;
    } sched_note_t;

endpackage

`default_nettype wire

// ==== funct_decode.sv ====
/* Sub-op lookup from funct3/funct7. Undefined branch codes give EQ,
   undefined system codes give ECALL. */
`timescale 1ns/1ps
`default_nettype none

module funct_decode
    import rv_decode_pkg::*;
(
    input  instr_u  instr,
    output alu_op_e alu_op,
    output br_op_e  br_op,
    output mul_op_e mul_op,
    output br_op_e  sys_op
);

    always_comb begin
        case (instr.r.funct3)
            3'h0: alu_op = (instr.r.opcode == OPC_R && instr.r.funct7[5]) ? ALU_SUB : ALU_ADD;
            3'h1: alu_op = ALU_SLL;
            3'h2: alu_op = ALU_SLT;
            3'h3: alu_op = ALU_SLTU;
            3'h4: alu_op = ALU_XOR;
            3'h5: alu_op = instr.r.funct7[5] ? ALU_SRA : ALU_SRL; // SRAI shares bit 30
            3'h6: alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
    end

    always_comb begin
        case (instr.b.funct3)
            3'h1: br_op = BR_NE;
            3'h4: br_op = BR_LT;
            3'h5: br_op = BR_GE;
            3'h6: br_op = BR_LTU;
            3'h7: br_op = BR_GEU;
            default: br_op = BR_EQ;
        endcase
    end

    // M ops are numbered in funct3 order
    assign mul_op = mul_op_e'({1'b0, instr.r.funct3});

    always_comb begin
        case (instr.i.imm)
            12'h001: sys_op = BR_EBREAK;
            12'h002: sys_op = BR_URET;
            12'h102: sys_op = BR_SRET;
            12'h302: sys_op = BR_MRET;
            default: sys_op = BR_ECALL;
        endcase
    end

endmodule

`default_nettype wire

// ==== imm_gen.sv ====
/* Immediate builder. IMM_CSR also covers the non-CSR system ops,
   which carry the constant 4 as their return offset. */
`timescale 1ns/1ps
`default_nettype none

module imm_gen
    import rv_decode_pkg::*;
(
    input  instr_u          instr,
    input  imm_fmt_e        fmt,
    output logic [XLEN-1:0] imm
);

    logic [11:0] s_imm;
    logic [12:0] b_imm;
    logic [20:0] j_imm;

    assign s_imm = {instr.s.imm_hi, instr.s.imm_lo};
    assign b_imm = {instr.b.imm12, instr.b.imm11, instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign j_imm = {instr.j.imm20, instr.j.imm19_12, instr.j.imm11, instr.j.imm10_1, 1'b0};

    always_comb begin
        case (fmt)
            IMM_I:    imm = XLEN'($signed(instr.i.imm));
            IMM_I_SH: imm = XLEN'(instr.r.rs2);           // shamt, zero-extended
            IMM_S:    imm = XLEN'($signed(s_imm));
            IMM_B:    imm = XLEN'($signed(b_imm));
            IMM_U:    imm = {instr.u.imm, 12'b0};
            IMM_J:    imm = XLEN'($signed(j_imm));
            IMM_CSR: begin
                if (instr.i.funct3[1:0] == 2'b00) begin
                    imm = XLEN'(4);                        // ECALL/EBREAK/xRET
                end else begin
                    // CSR address low, uimm in 16:12
                    imm = {{(XLEN - CSR_ADDR_W - NR_W){1'b0}}, instr.i.rs1, instr.i.imm};
                end
            end
            default:  imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== instr_decoder.sv ====
/* Main opcode decode for RV32IM plus Zicsr. Unknown opcodes fall out as an ALU
   op 0 with no operands. Register fields that are not used read as zero. */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
    import rv_decode_pkg::*;
(
    input  instr_u           instr,
    input  alu_op_e          alu_op,
    input  br_op_e           br_op,
    input  mul_op_e          mul_op,
    input  br_op_e           sys_op,
    output ex_type_e         ex_type,
    output logic [OP_W-1:0]  op_type,
    output logic [MOD_W-1:0] op_mod,
    output logic             use_pc,
    output logic             use_imm,
    output imm_fmt_e         imm_fmt,
    output logic             wb,
    output logic [NR_W-1:0]  rd,
    output logic [NR_W-1:0]  rs1,
    output logic [NR_W-1:0]  rs2,
    output logic             is_wstall
);

    logic       use_rd;
    logic [2:0] funct3;

    assign funct3 = instr.r.funct3;

    always_comb begin
        ex_type   = EX_ALU;
        op_type   = '0;
        op_mod    = '0;
        use_pc    = 1'b0;
        use_imm   = 1'b0;
        imm_fmt   = IMM_NONE;
        use_rd    = 1'b0;
        rd        = '0;
        rs1       = '0;
        rs2       = '0;
        is_wstall = 1'b0;

        case (instr.r.opcode)
            OPC_I: begin
                op_type = OP_W'(alu_op);
                use_imm = 1'b1;
                imm_fmt = (funct3[0] && !funct3[1]) ? IMM_I_SH : IMM_I;
                use_rd  = 1'b1;
                rd      = instr.r.rd;
                rs1     = instr.r.rs1;
            end
            OPC_R: begin
                if (instr.r.funct7[0]) begin
                    op_type   = OP_W'(mul_op);
                    op_mod[1] = 1'b1;
                end else begin
                    op_type = OP_W'(alu_op);
                end
                use_rd = 1'b1;
                rd     = instr.r.rd;
                rs1    = instr.r.rs1;
                rs2    = instr.r.rs2;
            end
            OPC_LUI, OPC_AUIPC: begin
                op_type = OP_W'(instr.r.opcode[5] ? ALU_LUI : ALU_AUIPC);
                use_pc  = !instr.r.opcode[5];
                use_imm = 1'b1;
                imm_fmt = IMM_U;
                use_rd  = 1'b1;
                rd      = instr.u.rd;
            end
            OPC_JAL: begin
                op_type   = OP_W'(BR_JAL);
                op_mod[0] = 1'b1;
                use_pc    = 1'b1;
                use_imm   = 1'b1;
                imm_fmt   = IMM_J;
                use_rd    = 1'b1;
                rd        = instr.j.rd;
                is_wstall = 1'b1;
            end
            OPC_JALR: begin
                op_type   = OP_W'(BR_JALR);
                op_mod[0] = 1'b1;
                use_imm   = 1'b1;
                imm_fmt   = IMM_I;
                use_rd    = 1'b1;
                rd        = instr.i.rd;
                rs1       = instr.i.rs1;
                is_wstall = 1'b1;
            end
            OPC_B: begin
                op_type   = OP_W'(br_op);
                op_mod[0] = 1'b1;
                use_pc    = 1'b1;
                use_imm   = 1'b1;
                imm_fmt   = IMM_B;
                rs1       = instr.b.rs1;
                rs2       = instr.b.rs2;
                is_wstall = 1'b1;
            end
            OPC_FENCE: begin
                ex_type = EX_LSU;
                op_type = LSU_FENCE;
            end
            OPC_SYS: begin
                imm_fmt   = IMM_CSR;
                use_rd    = 1'b1;
                rd        = instr.i.rd;
                is_wstall = 1'b1;
                case (funct3[1:0])
                    2'd1: op_type = SFU_CSRRW;
                    2'd2: op_type = SFU_CSRRS;
                    2'd3: op_type = SFU_CSRRC;
                    default: op_type = OP_W'(sys_op);
                endcase
                if (funct3[1:0] != 2'b00) begin
                    ex_type = EX_SFU;
                    use_imm = funct3[2];
                    rs1     = funct3[2] ? '0 : instr.i.rs1; // CSRxxI carries uimm instead
                end else begin
                    op_mod[0] = 1'b1;
                    use_pc    = 1'b1;
                    use_imm   = 1'b1;
                end
            end
            OPC_L: begin
                ex_type = EX_LSU;
                op_type = {1'b0, funct3};
                use_imm = 1'b1;
                imm_fmt = IMM_I;
                use_rd  = 1'b1;
                rd      = instr.i.rd;
                rs1     = instr.i.rs1;
            end
            OPC_S: begin
                ex_type = EX_LSU;
                op_type = {1'b1, funct3};
                use_imm = 1'b1;
                imm_fmt = IMM_S;
                rs1     = instr.s.rs1;
                rs2     = instr.s.rs2;
            end
            default: ;
        endcase
    end

    assign wb = use_rd && (rd != '0);  // x0 writes dropped

endmodule

`default_nettype wire

// ==== decode_buffer.sv ====
/* Two-entry skid buffer. in_ready comes from registers only and drops
   once the spare entry is taken; out_data holds while stalled. */
`timescale 1ns/1ps
`default_nettype none

module decode_buffer
    import rv_decode_pkg::*;
(
    input  wire      clk,
    input  wire      rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  decoded_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output decoded_t out_data
);

    logic     main_valid;
    logic     spare_valid;
    decoded_t main_data;
    decoded_t spare_data;
    logic     in_fire;
    logic     main_load;

    assign in_ready  = !spare_valid;
    assign in_fire   = in_valid && in_ready;
    assign main_load = !main_valid || out_ready;  // main slot empty or draining

    assign out_valid = main_valid;
    assign out_data  = main_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            main_valid  <= 1'b0;
            spare_valid <= 1'b0;
        end else if (main_load) begin
            main_valid  <= spare_valid || in_fire;
            spare_valid <= 1'b0;
        end else if (in_fire) begin
            spare_valid <= 1'b1;  // output stalled, park it
        end
    end

    always_ff @(posedge clk) begin
        if (main_load) begin
            main_data <= spare_valid ? spare_data : in_data;
        end
        if (in_fire && !main_load) begin
            spare_data <= in_data;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

    // Spare is only filled behind a held main entry
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        spare_valid |-> main_valid);

endmodule

`default_nettype wire

// ==== rv_decode.sv ====
/* Decode stage top. One instruction per fetch handshake; the scheduler note
   is combinational on the fetch fire and has no back-pressure. */
`timescale 1ns/1ps
`default_nettype none

module rv_decode
    import rv_decode_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  logic        fetch_valid,
    output logic        fetch_ready,
    input  fetch_t      fetch_data,
    output logic        dec_valid,
    input  logic        dec_ready,
    output decoded_t    dec_data,
    output logic        sched_valid,
    output sched_note_t sched_data
);

    alu_op_e  alu_op;
    br_op_e   br_op;
    mul_op_e  mul_op;
    br_op_e   sys_op;
    imm_fmt_e imm_fmt;
    logic     is_wstall;
    decoded_t dec_in;

    funct_decode u_funct_decode (
        .instr  (fetch_data.instr),
        .alu_op (alu_op),
        .br_op  (br_op),
        .mul_op (mul_op),
        .sys_op (sys_op)
    );

    instr_decoder u_instr_decoder (
        .instr     (fetch_data.instr),
        .alu_op    (alu_op),
        .br_op     (br_op),
        .mul_op    (mul_op),
        .sys_op    (sys_op),
        .ex_type   (dec_in.ex_type),
        .op_type   (dec_in.op_type),
        .op_mod    (dec_in.op_mod),
        .use_pc    (dec_in.use_pc),
        .use_imm   (dec_in.use_imm),
        .imm_fmt   (imm_fmt),
        .wb        (dec_in.wb),
        .rd        (dec_in.rd),
        .rs1       (dec_in.rs1),
        .rs2       (dec_in.rs2),
        .is_wstall (is_wstall)
    );

    imm_gen u_imm_gen (
        .instr (fetch_data.instr),
        .fmt   (imm_fmt),
        .imm   (dec_in.imm)
    );

    // Fetch-side fields pass straight into the buffer entry
    assign dec_in.wid   = fetch_data.wid;
    assign dec_in.tmask = fetch_data.tmask;
    assign dec_in.pc    = fetch_data.pc;

    decode_buffer u_decode_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (fetch_valid),
        .in_ready  (fetch_ready),
        .in_data   (dec_in),
        .out_valid (dec_valid),
        .out_ready (dec_ready),
        .out_data  (dec_data)
    );

    assign sched_valid          = fetch_valid && fetch_ready;
    assign sched_data.wid       = fetch_data.wid;
    assign sched_data.is_wstall = is_wstall;

endmodule

`default_nettype wire

// ==== tb_decode_model.svh ====
/* Reference decode and LFSR for the testbench, included inside tb_rv_decode.
   The model reads the raw instruction bits and never the package union. */
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

logic [31:0] lfsr_state;

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int k = 0; k < n; k++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        val        = {val[30:0], fb};
    end
    return val;
endfunction

function automatic logic [OP_W-1:0] alu_code(input logic [2:0] f3, input logic is_reg,
                                             input logic bit30);
    case (f3)
        3'd0: return (is_reg && bit30) ? ALU_SUB : ALU_ADD;
        3'd1: return ALU_SLL;
        3'd2: return ALU_SLT;
        3'd3: return ALU_SLTU;
        3'd4: return ALU_XOR;
        3'd5: return bit30 ? ALU_SRA : ALU_SRL;
        3'd6: return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

function automatic logic [OP_W-1:0] branch_code(input logic [2:0] f3);
    case (f3)
        3'd1: return BR_NE;
        3'd4: return BR_LT;
        3'd5: return BR_GE;
        3'd6: return BR_LTU;
        3'd7: return BR_GEU;
        default: return BR_EQ;  // 2 and 3 are undefined
    endcase
endfunction

function automatic logic [OP_W-1:0] sys_code(input logic [11:0] f12);
    case (f12)
        12'h001: return BR_EBREAK;
        12'h002: return BR_URET;
        12'h102: return BR_SRET;
        12'h302: return BR_MRET;
        default: return BR_ECALL;
    endcase
endfunction

function automatic decoded_t model_decode(input fetch_t f);
    decoded_t    d;
    logic [31:0] w;
    logic [2:0]  f3;
    logic        use_rd;
    w       = f.instr;
    f3      = w[14:12];
    use_rd  = 1'b0;
    d       = '0;
    d.wid   = f.wid;
    d.tmask = f.tmask;
    d.pc    = f.pc;
    case (w[6:0])
        OPC_I: begin
            d.op_type = alu_code(f3, 1'b0, w[30]);
            d.use_imm = 1'b1;
            d.imm     = (f3 == 3'd1 || f3 == 3'd5) ? {27'd0, w[24:20]} : {{20{w[31]}}, w[31:20]};
            d.rs1     = w[19:15];
            use_rd    = 1'b1;
        end
        OPC_R: begin
            d.op_type = w[25] ? {1'b0, f3} : alu_code(f3, 1'b1, w[30]);
            d.op_mod  = {w[25], 1'b0};
            d.rs1     = w[19:15];
            d.rs2     = w[24:20];
            use_rd    = 1'b1;
        end
        OPC_LUI, OPC_AUIPC: begin
            d.op_type = (w[6:0] == OPC_LUI) ? ALU_LUI : ALU_AUIPC;
            d.use_pc  = (w[6:0] == OPC_AUIPC);
            d.use_imm = 1'b1;
            d.imm     = {w[31:12], 12'd0};
            use_rd    = 1'b1;
        end
        OPC_JAL: begin
            d.op_type = BR_JAL;
            d.op_mod  = 2'b01;
            d.use_pc  = 1'b1;
            d.use_imm = 1'b1;
            d.imm     = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            use_rd    = 1'b1;
        end
        OPC_JALR: begin
            d.op_type = BR_JALR;
            d.op_mod  = 2'b01;
            d.use_imm = 1'b1;
            d.imm     = {{20{w[31]}}, w[31:20]};
            d.rs1     = w[19:15];
            use_rd    = 1'b1;
        end
        OPC_B: begin
            d.op_type = branch_code(f3);
            d.op_mod  = 2'b01;
            d.use_pc  = 1'b1;
            d.use_imm = 1'b1;
            d.imm     = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            d.rs1     = w[19:15];
            d.rs2     = w[24:20];
        end
        OPC_L: begin
            d.ex_type = EX_LSU;
            d.op_type = {1'b0, f3};
            d.use_imm = 1'b1;
            d.imm     = {{20{w[31]}}, w[31:20]};
            d.rs1     = w[19:15];
            use_rd    = 1'b1;
        end
        OPC_S: begin
            d.ex_type = EX_LSU;
            d.op_type = {1'b1, f3};
            d.use_imm = 1'b1;
            d.imm     = {{20{w[31]}}, w[31:25], w[11:7]};
            d.rs1     = w[19:15];
            d.rs2     = w[24:20];
        end
        OPC_FENCE: begin
            d.ex_type = EX_LSU;
            d.op_type = 4'd15;
        end
        OPC_SYS: begin
            use_rd = 1'b1;
            if (f3[1:0] != 2'b00) begin
                d.ex_type = EX_SFU;
                d.op_type = {2'b00, f3[1:0]};
                d.use_imm = f3[2];
                d.rs1     = f3[2] ? 5'd0 : w[19:15];  // uimm form
                d.imm     = {15'd0, w[19:15], w[31:20]};
            end else begin
                d.op_type = sys_code(w[31:20]);
                d.op_mod  = 2'b01;
                d.use_pc  = 1'b1;
                d.use_imm = 1'b1;
                d.imm     = 32'd4;
            end
        end
        default: ;  // NOP decode
    endcase
    if (use_rd) begin
        d.rd = w[11:7];
    end
    d.wb = use_rd && (w[11:7] != 5'd0);
    return d;
endfunction

function automatic sched_note_t model_sched(input fetch_t f);
    sched_note_t s;
    logic [31:0] w;
    w           = f.instr;
    s.wid       = f.wid;
    s.is_wstall = (w[6:0] == OPC_JAL) || (w[6:0] == OPC_JALR) ||
                  (w[6:0] == OPC_B) || (w[6:0] == OPC_SYS);
    return s;
endfunction

`endif

// ==== tb_rv_decode.sv ====
/* Random-stream testbench for rv_decode, 2000 instructions from a fixed LFSR seed.
   Fetch and execute sides toggle valid and ready at random. */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decode
    import rv_decode_pkg::*;
();

    logic        clk;
    logic        rst_n;
    logic        fetch_valid;
    logic        fetch_ready;
    fetch_t      fetch_data;
    logic        dec_valid;
    logic        dec_ready;
    decoded_t    dec_data;
    logic        sched_valid;
    sched_note_t sched_data;

    decoded_t    exp_q[$];  // accepted, not yet taken by execute
    logic        last_fire;
    int          sent;
    int          dec_errors;
    int          sched_errors;
    int          ctrl_errors;
    int          timeouts;

    `include "tb_decode_model.svh"

    rv_decode u_rv_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_data  (fetch_data),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec_data    (dec_data),
        .sched_valid (sched_valid),
        .sched_data  (sched_data)
    );

    always #50 clk = ~clk;

    task automatic check_decoded(input decoded_t got, input decoded_t exp);
        if (got !== exp) begin
            dec_errors++;
            $display("ERR dec_data got %h exp %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_sched(input sched_note_t got, input sched_note_t exp);
        if (got !== exp) begin
            sched_errors++;
            $display("ERR sched_data got %h exp %h at %0t", got, exp, $time);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            ctrl_errors++;
            $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
        end
    endtask

    // Mostly kept opcodes, about one in sixteen outside RV32IM
    function automatic logic [6:0] pick_opcode();
        logic [5:0] pick;
        pick = 6'(rand_bits(6));
        if (pick >= 6'd60) begin
            case (pick[1:0])
                2'd0: return 7'b0000111;  // FLW
                2'd1: return 7'b0011011;  // OP-IMM-32
                2'd2: return 7'b0001011;
                default: return 7'b0101011;
            endcase
        end
        case (pick % 6'd11)
            6'd0: return OPC_I;
            6'd1: return OPC_R;
            6'd2: return OPC_LUI;
            6'd3: return OPC_AUIPC;
            6'd4: return OPC_JAL;
            6'd5: return OPC_JALR;
            6'd6: return OPC_B;
            6'd7: return OPC_L;
            6'd8: return OPC_S;
            6'd9: return OPC_FENCE;
            default: return OPC_SYS;
        endcase
    endfunction

    function automatic fetch_t make_fetch();
        fetch_t      f;
        logic [31:0] w;
        f.wid   = WID_W'(rand_bits(WID_W));
        f.tmask = NUM_THREADS'(rand_bits(NUM_THREADS));
        f.pc    = rand_bits(30) << 2;
        w       = rand_bits(25) << 7;
        w[6:0]  = pick_opcode();
        if (3'(rand_bits(3)) == 3'd0) begin
            w[11:7] = 5'd0;  // rd = x0 now and then
        end
        // Steer system codes onto the trap and return encodings
        if (w[6:0] == OPC_SYS && w[13:12] == 2'b00) begin
            case (3'(rand_bits(3)))
                3'd0: w[31:20] = 12'h000;
                3'd1: w[31:20] = 12'h001;
                3'd2: w[31:20] = 12'h002;
                3'd3: w[31:20] = 12'h102;
                3'd4: w[31:20] = 12'h302;
                default: ;
            endcase
        end
        f.instr = w;
        return f;
    endfunction

    // Drive just after the rising edge, sample at the falling edge
    task automatic run_cycle();
        logic exp_ready;
        @(posedge clk);
        #1;
        if (!fetch_valid || last_fire) begin
            fetch_valid = (sent < 2000) && (rand_bits(2) != 0);
            fetch_data  = make_fetch();
        end
        dec_ready = (rand_bits(2) != 0);
        @(negedge clk);
        exp_ready = exp_q.size() < 2;  // room left in a two-entry buffer
        compare_flag("dec_valid", dec_valid, exp_q.size() != 0);
        compare_flag("fetch_ready", fetch_ready, exp_ready);
        last_fire = fetch_valid && fetch_ready;
        compare_flag("sched_valid", sched_valid, fetch_valid && exp_ready);
        if (fetch_valid && exp_ready) begin
            check_sched(sched_data, model_sched(fetch_data));
        end
        // Front is compared every valid cycle, so a held item must stay put
        if (dec_valid && exp_q.size() != 0) begin
            check_decoded(dec_data, exp_q[0]);
            if (dec_ready) begin
                void'(exp_q.pop_front());
            end
        end
        if (last_fire) begin
            exp_q.push_back(model_decode(fetch_data));
            sent++;
        end
    endtask

    initial begin
        int cycles;
        clk          = 1'b0;
        rst_n        = 1'b0;
        fetch_valid  = 1'b0;
        fetch_data   = '0;
        dec_ready    = 1'b0;
        lfsr_state   = 32'h528c13c6;
        last_fire    = 1'b0;
        sent         = 0;
        dec_errors   = 0;
        sched_errors = 0;
        ctrl_errors  = 0;
        timeouts     = 0;

        repeat (4) begin
            @(posedge clk);
            #1;
            compare_flag("dec_valid", dec_valid, 1'b0);
            compare_flag("sched_valid", sched_valid, 1'b0);
            compare_flag("fetch_ready", fetch_ready, 1'b1);
        end
        rst_n = 1'b1;

        cycles = 0;
        while (sent < 2000 && cycles < 20000) begin
            run_cycle();
            cycles++;
        end
        if (sent < 2000) begin
            timeouts++;
            $display("Timeout: only %0d of 2000 instructions were accepted", sent);
        end

        cycles = 0;
        while (exp_q.size() != 0 && cycles < 100) begin
            run_cycle();
            cycles++;
        end
        if (exp_q.size() != 0) begin
            timeouts++;
            $display("Timeout: %0d decoded items never left the buffer", exp_q.size());
        end
        repeat (4) run_cycle();  // catch late duplicates

        $display("Errors: decode %0d, sched %0d, control %0d, timeout %0d",
                 dec_errors, sched_errors, ctrl_errors, timeouts);
        if (dec_errors + sched_errors + ctrl_errors + timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_decode.f ====
+incdir+.
rv_decode_pkg.sv
funct_decode.sv
imm_gen.sv
instr_decoder.sv
decode_buffer.sv
rv_decode.sv
tb_rv_decode.sv

// ==== Makefile ====
TOP := tb_rv_decode

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run into sim.log, check for the pass line"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --assert --top-module $(TOP) -f rv_decode.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	@if grep -q "sim passed" sim.log; then \
		echo "PASS"; \
	else \
		echo "FAIL, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
